// ==== compile.f ====
+incdir+verilog
verilog/rs_pkg.sv
verilog/rs_entry_if.sv
verilog/priority_select.sv
verilog/rs_alloc.sv
verilog/rs_entries.sv
verilog/rs_issue.sv
verilog/rs_top.sv
test/rs_properties.sv
test/rs_tb.sv

// ==== Makefile ====
# Verilator build and run for the reservation station testbench

VERILATOR ?= verilator
TOP ?= rs_tb
FILE_LIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
HEADERS := $(wildcard verilog/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# the log decides pass or fail
run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/rs_tb.sv ====
`include "rs_config.svh"

module rs_tb;
    import rs_pkg::*;

    localparam int NUM = `RS_ENTRIES;
    localparam int SLOTS = `RS_DISPATCH_W;
    localparam int LANES = `RS_CDB_W;

    logic clock = 1'b0;
    logic reset;
    logic [SLOTS-1:0] dispatch_valid;
    tag_t [SLOTS-1:0] dispatch_dest;
    tag_t [SLOTS-1:0] dispatch_src1;
    tag_t [SLOTS-1:0] dispatch_src2;
    logic [SLOTS-1:0] dispatch_src1_ready;
    logic [SLOTS-1:0] dispatch_src2_ready;
    fu_class_t [SLOTS-1:0] dispatch_class;
    logic [SLOTS-1:0] stall;
    logic [LANES-1:0] cdb_valid;
    tag_t [LANES-1:0] cdb_tag;
    logic alu_ready;
    logic mult_ready;
    logic alu_issue_valid;
    tag_t alu_issue_dest;
    tag_t alu_issue_src1;
    tag_t alu_issue_src2;
    logic mult_issue_valid;
    tag_t mult_issue_dest;
    tag_t mult_issue_src1;
    tag_t mult_issue_src2;

    // model of the entry array
    logic model_valid [NUM];
    fu_class_t model_class [NUM];
    tag_t model_dest [NUM];
    tag_t model_src1 [NUM];
    tag_t model_src2 [NUM];
    logic model_rdy1 [NUM];
    logic model_rdy2 [NUM];

    // dut outputs as sampled mid-cycle
    logic [SLOTS-1:0] seen_stall;
    logic seen_alu_valid;
    tag_t seen_alu_dest;
    logic seen_mult_valid;
    tag_t seen_mult_dest;

    logic [31:0] lfsr_state;

    rs_top dut_i (.*);

    always #2 clock = ~clock;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic fb;
        value = '0;
        for (int b = 0; b < count; b++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    // tag broadcast on some valid lane this cycle
    function automatic logic on_cdb(input tag_t tag);
        logic hit;
        hit = 1'b0;
        for (int l = 0; l < LANES; l++) begin
            hit = hit | (cdb_valid[l] && cdb_tag[l] == tag);
        end
        return hit;
    endfunction

    task automatic report_fail(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_hex(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            report_fail($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_issue(input string unit, input int pick, input logic valid,
                               input tag_t dest, input tag_t src1, input tag_t src2);
        check_hex({unit, "_issue_valid"}, 32'(valid), 32'(pick >= 0));
        if (pick >= 0) begin
            check_hex({unit, "_issue_dest"}, 32'(dest), 32'(model_dest[pick]));
            check_hex({unit, "_issue_src1"}, 32'(src1), 32'(model_src1[pick]));
            check_hex({unit, "_issue_src2"}, 32'(src2), 32'(model_src2[pick]));
        end
    endtask

    // one cycle: sample and compare at the falling edge, step the model,
    // return at the next rising edge
    task automatic tick();
        entry_mask_t free;
        int alu_pick;
        int mult_pick;
        int slot_pick [SLOTS];
        int e;
        logic [SLOTS-1:0] exp_stall;
        @(negedge clock);
        seen_stall = stall;
        seen_alu_valid = alu_issue_valid;
        seen_alu_dest = alu_issue_dest;
        seen_mult_valid = mult_issue_valid;
        seen_mult_dest = mult_issue_dest;
        // descending scan leaves the lowest ready index
        alu_pick = -1;
        mult_pick = -1;
        for (int i = NUM - 1; i >= 0; i--) begin
            if (model_valid[i] && model_rdy1[i] && model_rdy2[i]) begin
                if (model_class[i] == FU_ALU && alu_ready) alu_pick = i;
                if (model_class[i] == FU_MULT && mult_ready) mult_pick = i;
            end
        end
        // issuing entries are free for allocation right away
        for (int i = 0; i < NUM; i++) begin
            free[i] = !model_valid[i] || i == alu_pick || i == mult_pick;
        end
        // slot 2 picks first, lowest free entry
        exp_stall = '0;
        for (int k = SLOTS - 1; k >= 0; k--) begin
            slot_pick[k] = -1;
            if (dispatch_valid[k]) begin
                for (int i = NUM - 1; i >= 0; i--) begin
                    if (free[i]) slot_pick[k] = i;
                end
                if (slot_pick[k] < 0) begin
                    exp_stall[k] = 1'b1;
                end else begin
                    free[slot_pick[k]] = 1'b0;
                end
            end
        end
        check_hex("stall", 32'(stall), 32'(exp_stall));
        check_issue("alu", alu_pick, alu_issue_valid, alu_issue_dest,
                    alu_issue_src1, alu_issue_src2);
        check_issue("mult", mult_pick, mult_issue_valid, mult_issue_dest,
                    mult_issue_src1, mult_issue_src2);
        // next edge: wakeup, clear issued, then load new entries
        for (int i = 0; i < NUM; i++) begin
            model_rdy1[i] = model_rdy1[i] || on_cdb(model_src1[i]);
            model_rdy2[i] = model_rdy2[i] || on_cdb(model_src2[i]);
            if (i == alu_pick || i == mult_pick) model_valid[i] = 1'b0;
        end
        for (int k = 0; k < SLOTS; k++) begin
            e = slot_pick[k];
            if (e >= 0) begin
                model_valid[e] = 1'b1;
                model_class[e] = dispatch_class[k];
                model_dest[e] = dispatch_dest[k];
                model_src1[e] = dispatch_src1[k];
                model_src2[e] = dispatch_src2[k];
                model_rdy1[e] = dispatch_src1_ready[k] || on_cdb(dispatch_src1[k]);
                model_rdy2[e] = dispatch_src2_ready[k] || on_cdb(dispatch_src2[k]);
            end
        end
        @(posedge clock);
    endtask

    task automatic drive_slot(input int k, input fu_class_t cls, input tag_t dest,
                              input tag_t src1, input logic rdy1,
                              input tag_t src2, input logic rdy2);
        dispatch_valid[k] <= 1'b1;
        dispatch_class[k] <= cls;
        dispatch_dest[k] <= dest;
        dispatch_src1[k] <= src1;
        dispatch_src1_ready[k] <= rdy1;
        dispatch_src2[k] <= src2;
        dispatch_src2_ready[k] <= rdy2;
    endtask

    task automatic idle_inputs();
        dispatch_valid <= '0;
        cdb_valid <= '0;
        alu_ready <= 1'b1;
        mult_ready <= 1'b1;
    endtask

    task automatic apply_reset();
        reset <= 1'b1;
        idle_inputs();
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        seen_stall = '0;
        for (int i = 0; i < NUM; i++) begin
            model_valid[i] = 1'b0;
        end
    endtask

    task automatic test_reset_idle();
        apply_reset();
        for (int c = 0; c < 3; c++) begin
            tick();
            check_hex("alu_issue_valid", 32'(seen_alu_valid), 32'h0);
            check_hex("mult_issue_valid", 32'(seen_mult_valid), 32'h0);
            check_hex("stall", 32'(seen_stall), 32'h0);
        end
    endtask

    task automatic test_single_issue();
        apply_reset();
        drive_slot(0, FU_MULT, 6'h21, 6'h02, 1'b1, 6'h03, 1'b1);
        tick();
        dispatch_valid <= '0;
        check_hex("mult_issue_valid", 32'(seen_mult_valid), 32'h0);
        tick();
        check_hex("mult_issue_valid", 32'(seen_mult_valid), 32'h1);
        check_hex("mult_issue_dest", 32'(seen_mult_dest), 32'h21);
        // gone after one issue
        tick();
        check_hex("mult_issue_valid", 32'(seen_mult_valid), 32'h0);
    endtask

    task automatic test_wakeup();
        apply_reset();
        drive_slot(2, FU_ALU, 6'h31, 6'h04, 1'b1, 6'h05, 1'b0);
        tick();
        dispatch_valid <= '0;
        for (int c = 0; c < 3; c++) begin
            tick();
            check_hex("alu_issue_valid", 32'(seen_alu_valid), 32'h0);
        end
        cdb_valid[1] <= 1'b1;
        cdb_tag[1] <= 6'h05;
        tick();
        cdb_valid <= '0;
        check_hex("alu_issue_valid", 32'(seen_alu_valid), 32'h0);
        tick();
        check_hex("alu_issue_valid", 32'(seen_alu_valid), 32'h1);
        check_hex("alu_issue_dest", 32'(seen_alu_dest), 32'h31);
        // broadcast in the dispatch cycle itself
        drive_slot(1, FU_ALU, 6'h32, 6'h07, 1'b0, 6'h04, 1'b1);
        cdb_valid[2] <= 1'b1;
        cdb_tag[2] <= 6'h07;
        tick();
        dispatch_valid <= '0;
        cdb_valid <= '0;
        tick();
        check_hex("alu_issue_valid", 32'(seen_alu_valid), 32'h1);
        check_hex("alu_issue_dest", 32'(seen_alu_dest), 32'h32);
    endtask

    task automatic test_fill_and_stall();
        int next_id;
        int filled;
        logic [SLOTS-1:0] exp_stall;
        next_id = 0;
        apply_reset();
        for (int c = 0; c < 4; c++) begin
            for (int k = SLOTS - 1; k >= 0; k--) begin
                // a stalled slot keeps its instruction for the retry
                if (!seen_stall[k]) begin
                    drive_slot(k, FU_ALU, tag_t'(32 + next_id), tag_t'(16 + next_id), 1'b0,
                               tag_t'(16 + next_id), 1'b0);
                    next_id++;
                end
            end
            filled = (c * SLOTS < NUM) ? c * SLOTS : NUM;
            for (int k = 0; k < SLOTS; k++) begin
                exp_stall[k] = filled + (SLOTS - k) > NUM;
            end
            tick();
            check_hex("stall", 32'(seen_stall), 32'(exp_stall));
        end
        // wake entry 0 while all three slots wait
        cdb_valid[0] <= 1'b1;
        cdb_tag[0] <= tag_t'(16);
        tick();
        cdb_valid <= '0;
        check_hex("stall", 32'(seen_stall), 32'h7);
        tick();
        check_hex("stall", 32'(seen_stall), 32'h3);
        check_hex("alu_issue_dest", 32'(seen_alu_dest), 32'd32);
        tick();
        check_hex("stall", 32'(seen_stall), 32'h7);
        idle_inputs();
    endtask

    task automatic test_backpressure();
        int waited;
        apply_reset();
        alu_ready <= 1'b0;
        for (int k = 0; k < SLOTS; k++) begin
            drive_slot(k, FU_ALU, tag_t'(48 + SLOTS - 1 - k), 6'h01, 1'b1, 6'h02, 1'b1);
        end
        tick();
        dispatch_valid <= '0;
        drive_slot(2, FU_MULT, 6'h38, 6'h01, 1'b1, 6'h02, 1'b1);
        drive_slot(1, FU_MULT, 6'h39, 6'h01, 1'b1, 6'h02, 1'b1);
        tick();
        dispatch_valid <= '0;
        check_hex("alu_issue_valid", 32'(seen_alu_valid), 32'h0);
        tick();
        check_hex("alu_issue_valid", 32'(seen_alu_valid), 32'h0);
        check_hex("mult_issue_dest", 32'(seen_mult_dest), 32'h38);
        alu_ready <= 1'b1;
        for (int n = 0; n < 3; n++) begin
            tick();
            check_hex("alu_issue_valid", 32'(seen_alu_valid), 32'h1);
            check_hex("alu_issue_dest", 32'(seen_alu_dest), 32'(48 + n));
            check_hex("mult_issue_valid", 32'(seen_mult_valid), 32'(n == 0));
        end
        waited = 0;
        while ((seen_alu_valid || seen_mult_valid) && waited < 10) begin
            tick();
            waited++;
        end
        assert (!seen_alu_valid && !seen_mult_valid) else begin
            report_fail("station kept issuing after the held entries drained");
        end
    endtask

    task automatic test_random();
        tag_t dest;
        tag_t src1;
        tag_t src2;
        logic rdy1;
        logic rdy2;
        fu_class_t cls;
        apply_reset();
        for (int c = 0; c < 200; c++) begin
            for (int k = 0; k < SLOTS; k++) begin
                cls = fu_class_t'(random_bits(1));
                dest = tag_t'(random_bits(6));
                // narrow tag space so the cdb hits often
                src1 = tag_t'(random_bits(3));
                src2 = tag_t'(random_bits(3));
                rdy1 = random_bits(2) == 32'd3;
                rdy2 = random_bits(2) == 32'd3;
                if (!seen_stall[k]) drive_slot(k, cls, dest, src1, rdy1, src2, rdy2);
            end
            dispatch_valid <= seen_stall | SLOTS'(random_bits(SLOTS));
            for (int l = 0; l < LANES; l++) begin
                cdb_tag[l] <= tag_t'(random_bits(3));
            end
            cdb_valid <= LANES'(random_bits(LANES));
            alu_ready <= random_bits(2) != 32'd0;
            mult_ready <= random_bits(2) != 32'd0;
            tick();
        end
        idle_inputs();
    endtask

    initial begin
        lfsr_state = 32'hed86_035d;
        reset = 1'b1;
        dispatch_valid = '0;
        dispatch_dest = '0;
        dispatch_src1 = '0;
        dispatch_src2 = '0;
        dispatch_src1_ready = '0;
        dispatch_src2_ready = '0;
        dispatch_class = '0;
        cdb_valid = '0;
        cdb_tag = '0;
        alu_ready = 1'b1;
        mult_ready = 1'b1;
        test_reset_idle();
        test_single_issue();
        test_wakeup();
        test_fill_and_stall();
        test_backpressure();
        test_random();
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== test/rs_properties.sv ====
`include "rs_config.svh"

module rs_properties (
    input logic clock,
    input logic reset,
    input logic [`RS_DISPATCH_W-1:0] dispatch_valid,
    input logic [`RS_DISPATCH_W-1:0] stall,
    input logic alu_ready,
    input logic mult_ready,
    input logic alu_issue_valid,
    input logic mult_issue_valid
);

    // stall only answers a slot offering work
    stall_needs_dispatch: assert property (
        @(posedge clock) disable iff (reset)
        (stall & ~dispatch_valid) == '0
    ) else $error("stall raised on an idle dispatch slot");

    // no issue into a busy unit
    alu_issue_needs_ready: assert property (
        @(posedge clock) disable iff (reset)
        alu_issue_valid |-> alu_ready
    ) else $error("alu issue while alu_ready low");

    mult_issue_needs_ready: assert property (
        @(posedge clock) disable iff (reset)
        mult_issue_valid |-> mult_ready
    ) else $error("mult issue while mult_ready low");

    issue_valid_known: assert property (
        @(posedge clock) disable iff (reset)
        !$isunknown({alu_issue_valid, mult_issue_valid})
    ) else $error("unknown value on an issue valid output");

endmodule

bind rs_top rs_properties props_i (
    .clock(clock),
    .reset(reset),
    .dispatch_valid(dispatch_valid),
    .stall(stall),
    .alu_ready(alu_ready),
    .mult_ready(mult_ready),
    .alu_issue_valid(alu_issue_valid),
    .mult_issue_valid(mult_issue_valid)
);

// ==== verilog/rs_top.sv ====
`include "rs_config.svh"

module rs_top (
    input logic clock,
    input logic reset,
    input logic [`RS_DISPATCH_W-1:0] dispatch_valid,
    input rs_pkg::tag_t [`RS_DISPATCH_W-1:0] dispatch_dest,
    input rs_pkg::tag_t [`RS_DISPATCH_W-1:0] dispatch_src1,
    input rs_pkg::tag_t [`RS_DISPATCH_W-1:0] dispatch_src2,
    input logic [`RS_DISPATCH_W-1:0] dispatch_src1_ready,
    input logic [`RS_DISPATCH_W-1:0] dispatch_src2_ready,
    input rs_pkg::fu_class_t [`RS_DISPATCH_W-1:0] dispatch_class,
    output logic [`RS_DISPATCH_W-1:0] stall,
    input logic [`RS_CDB_W-1:0] cdb_valid,
    input rs_pkg::tag_t [`RS_CDB_W-1:0] cdb_tag,
    input logic alu_ready,
    input logic mult_ready,
    output logic alu_issue_valid,
    output rs_pkg::tag_t alu_issue_dest,
    output rs_pkg::tag_t alu_issue_src1,
    output rs_pkg::tag_t alu_issue_src2,
    output logic mult_issue_valid,
    output rs_pkg::tag_t mult_issue_dest,
    output rs_pkg::tag_t mult_issue_src1,
    output rs_pkg::tag_t mult_issue_src2
);
    import rs_pkg::*;

    // shared view of the entry array
    rs_entry_if entries_if ();

    // per-slot entry grants, alloc to storage
    entry_mask_t [`RS_DISPATCH_W-1:0] grant;

    rs_entries entries_i (
        .clock(clock),
        .reset(reset),
        .entries(entries_if.storage),
        .grant(grant),
        .dispatch_dest(dispatch_dest),
        .dispatch_src1(dispatch_src1),
        .dispatch_src2(dispatch_src2),
        .dispatch_src1_ready(dispatch_src1_ready),
        .dispatch_src2_ready(dispatch_src2_ready),
        .dispatch_class(dispatch_class),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag)
    );

    // allocation sees this cycle's issue decision
    rs_alloc alloc_i (
        .entries(entries_if.alloc),
        .dispatch_valid(dispatch_valid),
        .grant(grant),
        .stall(stall)
    );

    rs_issue issue_i (
        .entries(entries_if.issue),
        .alu_ready(alu_ready),
        .mult_ready(mult_ready),
        .alu_issue_valid(alu_issue_valid),
        .mult_issue_valid(mult_issue_valid),
        .alu_issue_dest(alu_issue_dest),
        .alu_issue_src1(alu_issue_src1),
        .alu_issue_src2(alu_issue_src2),
        .mult_issue_dest(mult_issue_dest),
        .mult_issue_src1(mult_issue_src1),
        .mult_issue_src2(mult_issue_src2)
    );

endmodule

// ==== verilog/rs_issue.sv ====
`include "rs_config.svh"

module rs_issue (
    rs_entry_if.issue entries,
    input logic alu_ready,
    input logic mult_ready,
    output logic alu_issue_valid,
    output logic mult_issue_valid,
    output rs_pkg::tag_t alu_issue_dest,
    output rs_pkg::tag_t alu_issue_src1,
    output rs_pkg::tag_t alu_issue_src2,
    output rs_pkg::tag_t mult_issue_dest,
    output rs_pkg::tag_t mult_issue_src1,
    output rs_pkg::tag_t mult_issue_src2
);
    import rs_pkg::*;

    // both operands available
    entry_mask_t ready;

    // candidates per unit, empty while the unit is busy
    entry_mask_t alu_req;
    entry_mask_t mult_req;

    // one-hot winners
    entry_mask_t alu_gnt;
    entry_mask_t mult_gnt;

    assign ready = entries.valid & entries.src1_ready & entries.src2_ready;

    always_comb begin
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            alu_req[i] = alu_ready && ready[i] && entries.fu_class[i] == FU_ALU;
            mult_req[i] = mult_ready && ready[i] && entries.fu_class[i] == FU_MULT;
        end
    end

    // lowest ready index wins, no age order
    priority_select #(
        .WIDTH(`RS_ENTRIES)
    ) alu_sel_i (
        .req(alu_req),
        .gnt(alu_gnt),
        .any(alu_issue_valid)
    );

    priority_select #(
        .WIDTH(`RS_ENTRIES)
    ) mult_sel_i (
        .req(mult_req),
        .gnt(mult_gnt),
        .any(mult_issue_valid)
    );

    // classes are disjoint, so the two grants never collide
    assign entries.issued = alu_gnt | mult_gnt;

    // field mux, all zero when nothing is granted
    always_comb begin
        alu_issue_dest = '0;
        alu_issue_src1 = '0;
        alu_issue_src2 = '0;
        mult_issue_dest = '0;
        mult_issue_src1 = '0;
        mult_issue_src2 = '0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (alu_gnt[i]) begin
                alu_issue_dest = entries.dest[i];
                alu_issue_src1 = entries.src1[i];
                alu_issue_src2 = entries.src2[i];
            end
            if (mult_gnt[i]) begin
                mult_issue_dest = entries.dest[i];
                mult_issue_src1 = entries.src1[i];
                mult_issue_src2 = entries.src2[i];
            end
        end
    end

endmodule

// ==== verilog/rs_entries.sv ====
`include "rs_config.svh"

module rs_entries (
    input logic clock,
    input logic reset,
    rs_entry_if.storage entries,
    input rs_pkg::entry_mask_t [`RS_DISPATCH_W-1:0] grant,
    input rs_pkg::tag_t [`RS_DISPATCH_W-1:0] dispatch_dest,
    input rs_pkg::tag_t [`RS_DISPATCH_W-1:0] dispatch_src1,
    input rs_pkg::tag_t [`RS_DISPATCH_W-1:0] dispatch_src2,
    input logic [`RS_DISPATCH_W-1:0] dispatch_src1_ready,
    input logic [`RS_DISPATCH_W-1:0] dispatch_src2_ready,
    input rs_pkg::fu_class_t [`RS_DISPATCH_W-1:0] dispatch_class,
    input logic [`RS_CDB_W-1:0] cdb_valid,
    input rs_pkg::tag_t [`RS_CDB_W-1:0] cdb_tag
);
    import rs_pkg::*;

    localparam int SLOT_W = $clog2(`RS_DISPATCH_W);

    // entry is loaded this cycle
    entry_mask_t load;

    // which dispatch slot loads each entry
    logic [SLOT_W-1:0] slot_sel [`RS_ENTRIES];

    // tag seen on any valid cdb lane
    function automatic logic cdb_hit(
        input tag_t tag,
        input logic [`RS_CDB_W-1:0] lane_valid,
        input tag_t [`RS_CDB_W-1:0] lane_tag
    );
        logic hit;
        hit = 1'b0;
        for (int l = 0; l < `RS_CDB_W; l++) begin
            if (lane_valid[l] && lane_tag[l] == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // grants from different slots never overlap
    // so at most one slot hits a given entry
    always_comb begin
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            load[i] = 1'b0;
            slot_sel[i] = '0;
            for (int k = 0; k < `RS_DISPATCH_W; k++) begin
                if (grant[k][i]) begin
                    load[i] = 1'b1;
                    slot_sel[i] = SLOT_W'(k);
                end
            end
        end
    end

    // occupancy
    // a new load beats the clear of an entry issuing now
    always_ff @(posedge clock) begin
        if (reset) begin
            entries.valid <= '0;
        end else begin
            for (int i = 0; i < `RS_ENTRIES; i++) begin
                if (load[i]) begin
                    entries.valid[i] <= 1'b1;
                end else if (entries.issued[i]) begin
                    entries.valid[i] <= 1'b0;
                end
            end
        end
    end

    // payload and wakeup
    always_ff @(posedge clock) begin
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (load[i]) begin
                entries.fu_class[i] <= dispatch_class[slot_sel[i]];
                entries.dest[i] <= dispatch_dest[slot_sel[i]];
                entries.src1[i] <= dispatch_src1[slot_sel[i]];
                entries.src2[i] <= dispatch_src2[slot_sel[i]];
                // broadcast in the dispatch cycle counts too
                entries.src1_ready[i] <= dispatch_src1_ready[slot_sel[i]]
                    | cdb_hit(dispatch_src1[slot_sel[i]], cdb_valid, cdb_tag);
                entries.src2_ready[i] <= dispatch_src2_ready[slot_sel[i]]
                    | cdb_hit(dispatch_src2[slot_sel[i]], cdb_valid, cdb_tag);
            end else begin
                // ready bits only ever get set while held
                entries.src1_ready[i] <= entries.src1_ready[i]
                    | cdb_hit(entries.src1[i], cdb_valid, cdb_tag);
                entries.src2_ready[i] <= entries.src2_ready[i]
                    | cdb_hit(entries.src2[i], cdb_valid, cdb_tag);
            end
        end
    end

endmodule

// ==== verilog/rs_alloc.sv ====
`include "rs_config.svh"

module rs_alloc (
    rs_entry_if.alloc entries,
    input logic [`RS_DISPATCH_W-1:0] dispatch_valid,
    output rs_pkg::entry_mask_t [`RS_DISPATCH_W-1:0] grant,
    output logic [`RS_DISPATCH_W-1:0] stall
);
    import rs_pkg::*;

    // free entries
    // an entry issuing this cycle can be reused right away
    entry_mask_t free;

    // mask left over for each slot after higher slots picked
    entry_mask_t [`RS_DISPATCH_W-1:0] avail;

    // request mask per slot, empty for idle slots
    entry_mask_t [`RS_DISPATCH_W-1:0] req;

    // slot found an entry
    logic [`RS_DISPATCH_W-1:0] found;

    assign free = ~entries.valid | entries.issued;

    // highest slot sees the whole free mask
    assign avail[`RS_DISPATCH_W-1] = free;

    for (genvar k = `RS_DISPATCH_W - 1; k >= 0; k--) begin : g_slot
        // idle slot requests nothing, so its grant is empty
        // and the next slot sees the same mask
        assign req[k] = dispatch_valid[k] ? avail[k] : '0;

        priority_select #(
            .WIDTH(`RS_ENTRIES)
        ) sel_i (
            .req(req[k]),
            .gnt(grant[k]),
            .any(found[k])
        );

        // remove this slot's pick before the next one
        if (k > 0) begin : g_chain
            assign avail[k-1] = avail[k] & ~grant[k];
        end

        // stall only a valid slot that came up empty
        assign stall[k] = dispatch_valid[k] & ~found[k];
    end

endmodule

// ==== verilog/priority_select.sv ====
module priority_select #(
    parameter int WIDTH = 8
) (
    input logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] gnt,
    output logic any
);

    // lowest set bit wins
    // two's complement isolates it
    logic [WIDTH-1:0] req_neg;

    // ~req + 1 flips everything above the lowest one
    always_comb begin
        req_neg = ~req + WIDTH'(1);
    end

    // one-hot grant, zero when nothing requested
    always_comb begin
        gnt = req & req_neg;
    end

    // any request at all
    always_comb begin
        any = |req;
    end

endmodule

// ==== verilog/rs_entry_if.sv ====
`include "rs_config.svh"

interface rs_entry_if;
    import rs_pkg::*;

    // entry array as held in storage
    entry_mask_t valid;
    fu_class_t [`RS_ENTRIES-1:0] fu_class;
    tag_t [`RS_ENTRIES-1:0] dest;

    // source tags and their ready bits
    tag_t [`RS_ENTRIES-1:0] src1;
    entry_mask_t src1_ready;
    tag_t [`RS_ENTRIES-1:0] src2;
    entry_mask_t src2_ready;

    // entries leaving the station this cycle
    // at most one per unit
    entry_mask_t issued;

    // storage owns the array, clears issued entries
    modport storage (
        output valid,
        output fu_class,
        output dest,
        output src1,
        output src1_ready,
        output src2,
        output src2_ready,
        input issued
    );

    // issue side picks from the array
    modport issue (
        input valid,
        input fu_class,
        input dest,
        input src1,
        input src1_ready,
        input src2,
        input src2_ready,
        output issued
    );

    // allocation only needs occupancy
    modport alloc (
        input valid,
        input issued
    );

endinterface

// ==== verilog/rs_pkg.sv ====
`include "rs_config.svh"

package rs_pkg;

    // one physical register tag
    typedef logic [`RS_TAG_W-1:0] tag_t;

    // one bit per entry
    // used for valid masks, grants and issued masks
    typedef logic [`RS_ENTRIES-1:0] entry_mask_t;

    // functional unit class of an entry
    typedef logic [0:0] fu_class_t;

    // class codes
    // alu ops and multiplies are the only classes held here
    localparam fu_class_t FU_ALU = 1'b0;
    localparam fu_class_t FU_MULT = 1'b1;

endpackage

// ==== verilog/rs_config.svh ====
`ifndef RS_CONFIG_SVH
`define RS_CONFIG_SVH

// reservation station sizing

// number of station entries
`define RS_ENTRIES 8

// physical register tag width
`define RS_TAG_W 6

// dispatch slots per cycle, slot 2 allocates first
`define RS_DISPATCH_W 3

// common data bus tag lanes
`define RS_CDB_W 3

`endif
